// File: tape_pkg.sv
//============================================================================
// Tape package: tape store geometry, host download record and the
// capture and store structures of the fast-load path
//============================================================================

package tape_pkg;

	// Tape store geometry
	localparam int tape_depth = 16384;
	localparam int tape_aw    = 14;

	typedef logic [tape_aw-1:0] tape_addr_t;

	// Host download record, one byte per wr strobe
	typedef struct packed {
		logic        wr;     // Byte strobe
		logic        active; // High for the whole download
		logic [7:0]  index;  // Menu slot and file type
		logic [24:0] addr;   // Byte offset in the file
		logic [7:0]  data;
	} tape_dl_t;

	// Write port of the tape store
	typedef struct packed {
		logic       en;
		tape_addr_t addr;
		logic [7:0] data;
	} tape_wr_t;

	// Image description, valid once the download has ended
	typedef struct packed {
		tape_addr_t size; // Byte count, zero when empty
		logic       is_p; // .p image, else .o
	} tape_info_t;

endpackage

// File: zx_bus_pkg.sv
//============================================================================
// ZX bus package: CPU probe, RAM write port, ROM patch overlay, load
// routine windows, RAM bases and the bytes of the loader patch
//============================================================================

package zx_bus_pkg;

	// CPU bus as seen by the loader
	typedef struct packed {
		logic [15:0] addr;
		logic        m1_n; // Opcode fetch, active low
		logic        ce_p; // CPU clock enable, never in adjacent cycles
	} cpu_probe_t;

	typedef struct packed {
		logic        en;
		logic [15:0] addr;
		logic [7:0]  data;
	} ram_wr_t;

	// ROM overlay, data replaces the ROM byte while hit is high
	typedef struct packed {
		logic       hit;
		logic [7:0] data;
	} rom_patch_t;

	// ==========================================================================
	// Load routine windows
	// ==========================================================================
	localparam logic [15:0] zx81_entry = 16'h0347;
	localparam logic [15:0] zx81_end   = 16'h03C3;
	localparam logic [15:0] zx80_entry = 16'h0207;
	localparam logic [15:0] zx80_end   = 16'h024D;

	localparam logic [15:0] ram_base_o = 16'h4000; // .o files
	localparam logic [15:0] ram_base_p = 16'h4009; // .p files skip system vars

	// ==========================================================================
	// Patch: xor a / loop: nop or scf / jr nc,loop / jp back into ROM
	// ==========================================================================
	localparam int patch_len = 7;

	localparam logic [7:0] op_xor_a   = 8'hAF;
	localparam logic [7:0] op_nop     = 8'h00;
	localparam logic [7:0] op_scf     = 8'h37;
	localparam logic [7:0] op_jr_nc   = 8'h30;
	localparam logic [7:0] loop_disp  = 8'hFD; // Back to the nop/scf byte
	localparam logic [7:0] op_jp      = 8'hC3;
	localparam logic [7:0] jp_lo_zx81 = 8'h07; // 0207h
	localparam logic [7:0] jp_lo_zx80 = 8'h03; // 0203h
	localparam logic [7:0] jp_hi      = 8'h02;

endpackage

// File: tape_capture.sv
//============================================================================
// Tape capture: filters host downloads down to tape images, forwards the
// bytes to the tape store and records size and format at the end
//============================================================================
`timescale 1ns/100ps

module tape_capture (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  tape_pkg::tape_dl_t    dl,
	output tape_pkg::tape_wr_t    tape_wr,
	output tape_pkg::tape_info_t  info,
	output logic                  tape_ready
);
	import tape_pkg::*;

	logic       is_tape;
	logic       active_q;
	logic       wr_en;
	tape_addr_t wr_addr;
	logic [7:0] wr_data;
	tape_addr_t size;
	logic       is_p;

	// Tape slots have a nonzero slot number and bits 7 and 5 clear
	assign is_tape = (dl.index[4:0] != 5'd0) && !dl.index[7] && !dl.index[5];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_en    <= 1'b0;
			active_q <= 1'b0;
			size     <= '0;
		end else begin
			wr_en    <= dl.wr && is_tape;
			active_q <= dl.active;
			if (is_tape && active_q && !dl.active)
				size <= dl.addr[tape_aw-1:0]; // Byte count of the finished file
		end
	end

	always_ff @(posedge clk_sys) begin
		wr_addr <= dl.addr[tape_aw-1:0];
		wr_data <= dl.data;
		if (is_tape && active_q && !dl.active)
			is_p <= dl.index[6];
	end

	assign tape_wr    = '{en: wr_en, addr: wr_addr, data: wr_data};
	assign info       = '{size: size, is_p: is_p};
	assign tape_ready = (size != '0);

	// Image must fit the store, larger files would wrap over the start
	a_tape_fits: assert property (@(posedge clk_sys) disable iff (reset)
		(dl.wr && is_tape) |-> (dl.addr < tape_depth));

endmodule

// File: tape_store.sv
//============================================================================
// Tape store: 16 KB image memory, one write port, registered read
//============================================================================
`timescale 1ns/100ps

module tape_store (
	input  logic                 clk_sys,
	input  tape_pkg::tape_wr_t   tape_wr,
	input  tape_pkg::tape_addr_t rd_addr,
	output logic [7:0]           rd_data
);
	import tape_pkg::*;

	logic [7:0] mem [tape_depth];

	// Written only by the host download
	always_ff @(posedge clk_sys) begin
		if (tape_wr.en)
			mem[tape_wr.addr] <= tape_wr.data;
	end

	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr]; // Data one cycle after the address
	end

endmodule

// File: tape_injector.sv
//============================================================================
// Tape injector: catches the ROM load routine, overlays a spin loop on
// it and copies the tape image into main RAM on CPU clock enables
//============================================================================
`timescale 1ns/100ps

module tape_injector (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     zx81,
	input  zx_bus_pkg::cpu_probe_t   cpu,
	input  tape_pkg::tape_info_t     info,
	input  logic                     tape_ready,
	input  logic [7:0]               rd_data,
	output tape_pkg::tape_addr_t     rd_addr,
	output zx_bus_pkg::ram_wr_t      ram_wr,
	output zx_bus_pkg::rom_patch_t   patch,
	output logic                     loading
);
	import tape_pkg::*;
	import zx_bus_pkg::*;

	logic        zx81_q;     // Model, sampled during reset
	logic        m1_q;
	logic        m1_fall;
	logic [15:0] entry;
	logic [15:0] win_end;
	logic [7:0]  jp_lo;
	logic [15:0] ram_base;
	logic        entry_hit;
	logic        exit_hit;
	logic        more;       // Bytes left to copy
	logic        step;
	tape_addr_t  offset;
	tape_addr_t  offset_nxt;
	logic        wr_en;
	logic [15:0] wr_addr;
	logic [7:0]  wr_data;
	logic [7:0]  patch_b1;   // nop while copying, scf when done
	logic [7:0]  patch_b5;   // Low byte of the jump back
	logic [15:0] patch_off;

	// ==========================================================================
	// Model window and M1 edge
	// ==========================================================================
	assign entry    = zx81_q ? zx81_entry : zx80_entry;
	assign win_end  = zx81_q ? zx81_end   : zx80_end;
	assign jp_lo    = zx81_q ? jp_lo_zx81 : jp_lo_zx80;
	assign ram_base = info.is_p ? ram_base_p : ram_base_o;

	assign m1_fall   = !cpu.m1_n && m1_q;
	assign entry_hit = m1_fall && tape_ready && (cpu.addr == entry);
	assign exit_hit  = m1_fall && ((cpu.addr < entry) || (cpu.addr >= win_end));

	assign more = (offset < info.size);
	assign step = loading && cpu.ce_p && more;

	// Store is addressed with the next offset so rd_data tracks offset
	always_comb begin
		offset_nxt = offset;
		if (step)
			offset_nxt = offset + 1'b1;
		if (entry_hit)
			offset_nxt = '0;
	end

	assign rd_addr = offset_nxt;

	always_ff @(posedge clk_sys) begin
		if (reset)
			zx81_q <= zx81;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m1_q    <= 1'b1;
			loading <= 1'b0;
			wr_en   <= 1'b0;
			offset  <= '0;
		end else begin
			m1_q   <= cpu.m1_n;
			wr_en  <= step;
			offset <= offset_nxt;
			if (exit_hit)
				loading <= 1'b0; // CPU left the load routine
			if (entry_hit)
				loading <= 1'b1;
		end
	end

	// RAM write payload, address is base plus the byte just read
	always_ff @(posedge clk_sys) begin
		if (step) begin
			wr_addr <= ram_base + {2'b00, offset};
			wr_data <= rd_data;
		end
	end

	assign ram_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

	// ==========================================================================
	// Patch table
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (loading && !more)
			patch_b1 <= op_scf;  // Releases the jr nc loop
		if (entry_hit) begin
			patch_b1 <= op_nop;
			patch_b5 <= jp_lo;
		end
	end

	assign patch_off = cpu.addr - entry; // Wraps high below entry

	always_comb begin
		patch.hit = loading && (patch_off < 16'(patch_len));
		case (patch_off[2:0])
			3'd0:    patch.data = op_xor_a;
			3'd1:    patch.data = patch_b1;
			3'd2:    patch.data = op_jr_nc;
			3'd3:    patch.data = loop_disp;
			3'd4:    patch.data = op_jp;
			3'd5:    patch.data = patch_b5;
			default: patch.data = jp_hi;
		endcase
	end

	// Copy ends before the CPU leaves the routine
	a_wr_in_load: assert property (@(posedge clk_sys) disable iff (reset)
		ram_wr.en |-> loading);

	// Loop stays closed while bytes remain
	a_loop_closed: assert property (@(posedge clk_sys) disable iff (reset)
		(loading && more) |-> (patch_b1 == op_nop));

	// Read latency of the store relies on this spacing
	a_ce_spacing: assert property (@(posedge clk_sys) disable iff (reset)
		cpu.ce_p |=> !cpu.ce_p);

endmodule

// File: zx_tape_top.sv
//============================================================================
// Tape fast-load top: capture, tape store and RAM injector
//============================================================================
`timescale 1ns/100ps

module zx_tape_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  tape_pkg::tape_dl_t      dl,
	input  zx_bus_pkg::cpu_probe_t  cpu,
	input  logic                    zx81,
	output zx_bus_pkg::ram_wr_t     ram_wr,
	output zx_bus_pkg::rom_patch_t  patch,
	output logic                    tape_ready,
	output logic                    loading
);
	import tape_pkg::*;

	tape_wr_t   tape_wr;
	tape_info_t info;
	tape_addr_t rd_addr;
	logic [7:0] rd_data;

	tape_capture u_capture (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.tape_wr    (tape_wr),
		.info       (info),
		.tape_ready (tape_ready)
	);

	tape_store u_store (
		.clk_sys (clk_sys),
		.tape_wr (tape_wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	tape_injector u_injector (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.zx81       (zx81),
		.cpu        (cpu),
		.info       (info),
		.tape_ready (tape_ready),
		.rd_data    (rd_data),
		.rd_addr    (rd_addr),
		.ram_wr     (ram_wr),
		.patch      (patch),
		.loading    (loading)
	);

endmodule

// File: tb_zx_tape.sv
//============================================================================
// Testbench for the tape fast-load path: downloads LFSR images, triggers
// the ROM load routine and checks the patch overlay and the RAM writes
//============================================================================
`timescale 1ns/100ps

module tb_zx_tape;
	import tape_pkg::*;
	import zx_bus_pkg::*;

	localparam int len_p = 48;  // ZX81 .p image
	localparam int len_o = 40;  // ZX80 .o image
	localparam int timeout_cycles = 10 * (len_p + len_o) + 400;

	logic        clk_sys;
	logic        reset;
	logic        zx81;
	tape_dl_t    dl;
	cpu_probe_t  cpu;
	ram_wr_t     ram_wr;
	rom_patch_t  patch;
	logic        tape_ready;
	logic        loading;

	logic [7:0]  img [tape_depth];  // Expected tape image
	logic [31:0] lfsr;
	logic [15:0] wr_count;          // RAM writes since reset
	logic [15:0] exp_base;
	logic [15:0] exp_size;
	logic        wr_open;           // RAM writes are expected
	logic [15:0] exp_addr;
	logic [7:0]  exp_data;
	int          errors;
	int          errors_before;
	int          tests;
	int          tests_failed;
	int          cycles;

	zx_tape_top UUT (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.cpu        (cpu),
		.zx81       (zx81),
		.ram_wr     (ram_wr),
		.patch      (patch),
		.tape_ready (tape_ready),
		.loading    (loading)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		if (reset)
			wr_count <= '0;
		else if (ram_wr.en)
			wr_count <= wr_count + 1'b1;
	end

	assign exp_addr = exp_base + wr_count;
	assign exp_data = img[wr_count[tape_aw-1:0]];

	// ==========================================================================
	// RAM write checks
	// ==========================================================================
	a_wr_allowed: assert property (@(posedge clk_sys) disable iff (reset)
		ram_wr.en |-> (wr_open && (wr_count < exp_size)))
		else begin
			$display("Unexpected RAM write to %h after %0d writes",
				$sampled(ram_wr.addr), $sampled(wr_count));
			errors++;
		end

	a_wr_addr: assert property (@(posedge clk_sys) disable iff (reset)
		ram_wr.en |-> (ram_wr.addr == exp_addr))
		else begin
			$display("FAIL ram_wr.addr got %h exp %h",
				$sampled(ram_wr.addr), $sampled(exp_addr));
			errors++;
		end

	a_wr_data: assert property (@(posedge clk_sys) disable iff (reset)
		ram_wr.en |-> (ram_wr.data == exp_data))
		else begin
			$display("FAIL ram_wr.data got %h exp %h",
				$sampled(ram_wr.data), $sampled(exp_data));
			errors++;
		end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		repeat (n) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	task automatic check_val(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp)
		else begin
			$display("FAIL %s got %h exp %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != errors_before) begin
			tests_failed++;
			$display("test %0d %s: failed", tests, name);
		end else begin
			$display("test %0d %s: passed", tests, name);
		end
		errors_before = errors;
	endtask

	task automatic reset_dut(input logic model_zx81);
		@(posedge clk_sys);
		reset <= 1'b1;
		zx81  <= model_zx81;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic fill_image(input int len);
		logic [7:0] b;
		for (int i = 0; i < len; i++) begin
			take_bits(8, b);
			img[i] = b;
		end
	endtask

	// One byte per two cycles, then active falls with the byte count on addr
	task automatic download(input logic [7:0] index, input int len);
		for (int i = 0; i < len; i++) begin
			@(posedge clk_sys);
			dl <= '{wr: 1'b1, active: 1'b1, index: index, addr: 25'(i), data: img[i]};
			@(posedge clk_sys);
			dl.wr <= 1'b0;
		end
		@(posedge clk_sys);
		dl.active <= 1'b0;
		dl.addr   <= 25'(len);
		repeat (2) @(posedge clk_sys);
		dl <= '0;
		@(negedge clk_sys);
	endtask

	task automatic m1_edge(input logic [15:0] addr);
		@(posedge clk_sys);
		cpu.addr <= addr;
		cpu.m1_n <= 1'b0;
		@(posedge clk_sys);
		cpu.m1_n <= 1'b1;
	endtask

	task automatic wait_loading(input logic level);
		int n;
		n = 0;
		@(negedge clk_sys);
		while ((loading !== level) && (n < 20)) begin
			@(negedge clk_sys);
			n++;
		end
		if (loading !== level) begin
			$display("loading did not go to %0b within 20 cycles", level);
			errors++;
		end
	endtask

	task automatic read_patch(input logic [15:0] addr, input logic hit,
			input logic [7:0] data);
		@(posedge clk_sys);
		cpu.addr <= addr;
		@(negedge clk_sys);
		check_val("patch.hit", 16'(patch.hit), 16'(hit));
		if (hit)
			check_val("patch.data", 16'(patch.data), 16'(data));
	endtask

	// xor a / nop / jr nc,-3 / jp 02xxh
	task automatic check_patch(input logic [15:0] entry, input logic [7:0] jump_lo);
		logic [7:0] exp;
		for (int k = 0; k < 7; k++) begin
			case (k)
				0:       exp = 8'hAF;
				1:       exp = 8'h00;
				2:       exp = 8'h30;
				3:       exp = 8'hFD;
				4:       exp = 8'hC3;
				5:       exp = jump_lo;
				default: exp = 8'h02;
			endcase
			read_patch(entry + 16'(k), 1'b1, exp);
		end
		read_patch(entry + 16'd7, 1'b0, 8'h00);
	endtask

	// A few extra enables past the end must not write
	task automatic stream(input logic [15:0] base, input int len);
		logic [7:0] gap;
		@(posedge clk_sys);
		exp_base <= base;
		exp_size <= 16'(len);
		wr_open  <= 1'b1;
		for (int i = 0; i < len + 3; i++) begin
			@(posedge clk_sys);
			cpu.ce_p <= 1'b1;
			@(posedge clk_sys);
			cpu.ce_p <= 1'b0;
			take_bits(2, gap);
			repeat (gap) @(posedge clk_sys);
		end
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_val("wr_count", wr_count, 16'(len));
		@(posedge clk_sys);
		wr_open <= 1'b0;
	endtask

	task automatic idle_pulses(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			cpu.ce_p <= 1'b1;
			@(posedge clk_sys);
			cpu.ce_p <= 1'b0;
		end
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	initial begin
		reset    <= 1'b1;
		zx81     <= 1'b1;
		dl       <= '0;
		cpu      <= '{addr: 16'h0000, m1_n: 1'b1, ce_p: 1'b0};
		exp_base <= '0;
		exp_size <= '0;
		wr_open  <= 1'b0;
		lfsr          = 32'h7d3f_ede2;
		errors        = 0;
		errors_before = 0;
		tests         = 0;
		tests_failed  = 0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);

		check_val("tape_ready", 16'(tape_ready), 16'h0);
		check_val("loading", 16'(loading), 16'h0);
		check_val("ram_wr.en", 16'(ram_wr.en), 16'h0);
		check_val("patch.hit", 16'(patch.hit), 16'h0);
		end_test("reset state");

		fill_image(len_p);
		download(8'h00, 4);
		check_val("tape_ready", 16'(tape_ready), 16'h0);
		download(8'h21, 4);   // Bit 5 set
		check_val("tape_ready", 16'(tape_ready), 16'h0);
		download(8'h81, 4);   // Bit 7 set
		check_val("tape_ready", 16'(tape_ready), 16'h0);
		download(8'h41, len_p);
		check_val("tape_ready", 16'(tape_ready), 16'h1);
		end_test("download filter");

		m1_edge(16'h0347);
		wait_loading(1'b1);
		check_patch(16'h0347, 8'h07);
		end_test("zx81 entry patch");

		stream(16'h4009, len_p);
		read_patch(16'h0348, 1'b1, 8'h37);
		end_test("zx81 p stream");

		m1_edge(16'h03C3);
		wait_loading(1'b0);
		idle_pulses(4);
		check_val("wr_count", wr_count, 16'(len_p));
		read_patch(16'h0347, 1'b0, 8'h00);
		end_test("zx81 exit");

		reset_dut(1'b0);
		fill_image(len_o);
		download(8'h03, len_o);
		m1_edge(16'h0207);
		wait_loading(1'b1);
		check_patch(16'h0207, 8'h03);
		stream(16'h4000, len_o);
		read_patch(16'h0208, 1'b1, 8'h37);
		m1_edge(16'h0100);  // Below entry
		wait_loading(1'b0);
		end_test("zx80 o load");

		$display("%0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: project.f
tape_pkg.sv
zx_bus_pkg.sv
tape_capture.sv
tape_store.sv
tape_injector.sv
zx_tape_top.sv
tb_zx_tape.sv

// File: run_sim.sh
#!/bin/sh
# Build the tape fast-load testbench with Verilator, run it and check the log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_zx_tape -f project.f -o Vtb_zx_tape \
	&& ./obj_dir/Vtb_zx_tape > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "=== PASS ===" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
